// File: lsq_pkg.sv
package lsq_pkg;

    // ################################################
    // sizes
    // ################################################

    localparam int ROB_DEPTH        = 6;
    localparam int NUM_LDST_RS      = 3;
    localparam int STORE_CNT_W      = 3;
    localparam int MEM_WORDS        = 256;
    localparam int MEM_READ_LATENCY = 2;

    localparam int RS_IDX_W   = $clog2(NUM_LDST_RS);
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);
    localparam int LAT_CNT_W  = $clog2(MEM_READ_LATENCY + 1);

    // RV32I funct3 codes for loads and stores.
    localparam logic [2:0] lb  = 3'b000;
    localparam logic [2:0] lh  = 3'b001;
    localparam logic [2:0] lw  = 3'b010;
    localparam logic [2:0] lbu = 3'b100;
    localparam logic [2:0] lhu = 3'b101;
    localparam logic [2:0] sb  = 3'b000;
    localparam logic [2:0] sh  = 3'b001;
    localparam logic [2:0] sw  = 3'b010;

    // load issue FSM states.
    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_BUSY = 1'b1;

    typedef logic [31:0] xlen_word;
    typedef logic [2:0]  tag_t;

    // ################################################
    // shared structs
    // ################################################

    typedef struct packed {
        logic       is_store;
        logic [2:0] funct;
        xlen_word   vj;
        xlen_word   vk;
        tag_t       qj;
        tag_t       qk;
        xlen_word   imm;
        tag_t       dest;
    } lsb_dispatch_t;

    typedef struct packed {
        logic [ROB_DEPTH:0]     ready;
        xlen_word [ROB_DEPTH:0] vals;
    } rob_bcast_t;

    // one lane per buffer entry; funct lets the store queue size the write.
    typedef struct packed {
        logic [NUM_LDST_RS-1:0]       valid;
        logic [NUM_LDST_RS-1:0]       is_store;
        logic [NUM_LDST_RS-1:0][2:0]  funct;
        tag_t [NUM_LDST_RS-1:0]       tag;
        xlen_word [NUM_LDST_RS-1:0]   val;
        xlen_word [NUM_LDST_RS-1:0]   addr;
    } mem_cdb_t;

    typedef struct packed {
        logic                  valid;
        logic [MEM_ADDR_W-1:0] addr;
        logic [3:0]            mask;
        xlen_word              data;
    } mem_wr_t;

endpackage

// File: load_align.sv
`timescale 1ns/1ps

module load_align
    import lsq_pkg::*;
(
    input  logic [2:0] funct,
    input  logic [1:0] offset,
    input  xlen_word   rdata,
    output xlen_word   val
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // pick the addressed lanes first, extension follows from funct.
    always_comb
    begin
        byte_sel = rdata[{offset, 3'b000} +: 8];
        half_sel = offset[1] ? rdata[31:16] : rdata[15:0];
    end

    always_comb
    begin
        case (funct)
            lb:
            begin
                val = {{24{byte_sel[7]}}, byte_sel};
            end
            lbu:
            begin
                val = {24'b0, byte_sel};
            end
            lh:
            begin
                val = {{16{half_sel[15]}}, half_sel};
            end
            lhu:
            begin
                val = {16'b0, half_sel};
            end
            default:
            begin
                val = rdata;
            end
        endcase
    end

endmodule

// File: lsb_rs.sv
`timescale 1ns/1ps

module lsb_rs
    import lsq_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          dispatch_valid,
    input  lsb_dispatch_t dispatch,
    output logic          lsb_ready,
    input  logic          new_store,
    input  rob_bcast_t    rob_data,
    output mem_cdb_t      mem_res,
    output logic          mem_read,
    output xlen_word      mem_addr,
    input  logic          mem_resp,
    input  xlen_word      mem_rdata
);

    // ################################################
    // entry storage
    // ################################################

    logic                   busy         [NUM_LDST_RS];
    logic                   is_store     [NUM_LDST_RS];
    logic [2:0]             funct        [NUM_LDST_RS];
    xlen_word               vj           [NUM_LDST_RS];
    xlen_word               vk           [NUM_LDST_RS];
    xlen_word               imm          [NUM_LDST_RS];
    tag_t                   qj           [NUM_LDST_RS];
    tag_t                   qk           [NUM_LDST_RS];
    tag_t                   dest         [NUM_LDST_RS];
    logic [STORE_CNT_W-1:0] store_before [NUM_LDST_RS];

    logic [STORE_CNT_W-1:0] store_count;
    logic [STORE_CNT_W-1:0] store_snap;
    logic                   free_found;
    logic [RS_IDX_W-1:0]    free_idx;
    logic                   push;
    logic [NUM_LDST_RS-1:0] store_go;
    logic [NUM_LDST_RS-1:0] entry_done;
    logic                   load_found;
    logic [RS_IDX_W-1:0]    load_idx;
    logic                   state;
    logic [RS_IDX_W-1:0]    issue_idx;
    logic                   load_done;
    xlen_word               load_val;

    // lowest free entry takes the next dispatch.
    always_comb
    begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = NUM_LDST_RS - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                free_found = 1'b1;
                free_idx   = RS_IDX_W'(i);
            end
        end
    end

    assign lsb_ready = free_found;
    assign push      = dispatch_valid && free_found;

    // a load dispatched alongside a commit must not count that store.
    assign store_snap = new_store ? store_count - 1'b1 : store_count;

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            store_count <= '0;
        end
        else if (push && dispatch.is_store && !new_store)
        begin
            store_count <= store_count + 1'b1;
        end
        else if (!(push && dispatch.is_store) && new_store)
        begin
            store_count <= store_count - 1'b1;
        end
    end

    // ################################################
    // readiness and completion
    // ################################################

    always_comb
    begin
        load_found = 1'b0;
        load_idx   = '0;
        for (int i = NUM_LDST_RS - 1; i >= 0; i--)
        begin
            store_go[i] = busy[i] && is_store[i] && qj[i] == '0 && qk[i] == '0;
            if (busy[i] && !is_store[i] && qj[i] == '0 && store_before[i] == '0)
            begin
                load_found = 1'b1;
                load_idx   = RS_IDX_W'(i);
            end
        end
    end

    assign load_done = (state == ST_BUSY) && mem_resp;

    always_comb
    begin
        for (int i = 0; i < NUM_LDST_RS; i++)
        begin
            entry_done[i] = store_go[i] || (load_done && issue_idx == RS_IDX_W'(i));
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            for (int i = 0; i < NUM_LDST_RS; i++)
            begin
                busy[i]         <= 1'b0;
                qj[i]           <= '0;
                qk[i]           <= '0;
                store_before[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < NUM_LDST_RS; i++)
            begin
                if (push && free_idx == RS_IDX_W'(i))
                begin
                    busy[i]         <= 1'b1;
                    is_store[i]     <= dispatch.is_store;
                    funct[i]        <= dispatch.funct;
                    vj[i]           <= dispatch.vj;
                    vk[i]           <= dispatch.vk;
                    qj[i]           <= dispatch.qj;
                    qk[i]           <= dispatch.qk;
                    imm[i]          <= dispatch.imm;
                    dest[i]         <= dispatch.dest;
                    store_before[i] <= store_snap;
                end
                else
                begin
                    if (entry_done[i])
                    begin
                        busy[i] <= 1'b0;
                    end
                    // operand capture from the ROB broadcast.
                    if (qj[i] != '0 && rob_data.ready[qj[i]])
                    begin
                        qj[i] <= '0;
                        vj[i] <= rob_data.vals[qj[i]];
                    end
                    if (qk[i] != '0 && rob_data.ready[qk[i]])
                    begin
                        qk[i] <= '0;
                        vk[i] <= rob_data.vals[qk[i]];
                    end
                    if (new_store && busy[i] && !is_store[i] && store_before[i] != '0)
                    begin
                        store_before[i] <= store_before[i] - 1'b1;
                    end
                end
            end
        end
    end

    // ################################################
    // load issue and result bus
    // ################################################

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            state <= ST_IDLE;
        end
        else if (state == ST_IDLE)
        begin
            if (load_found)
            begin
                state     <= ST_BUSY;
                issue_idx <= load_idx;
                mem_addr  <= vj[load_idx] + imm[load_idx];
            end
        end
        else if (mem_resp)
        begin
            state <= ST_IDLE;
        end
    end

    assign mem_read = (state == ST_BUSY);

    load_align u_load_align (
        .funct  (funct[issue_idx]),
        .offset (mem_addr[1:0]),
        .rdata  (mem_rdata),
        .val    (load_val)
    );

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            mem_res.valid <= '0;
        end
        else
        begin
            for (int i = 0; i < NUM_LDST_RS; i++)
            begin
                mem_res.valid[i] <= entry_done[i];
                mem_res.is_store[i] <= is_store[i];
                mem_res.funct[i]    <= funct[i];
                mem_res.tag[i]      <= dest[i];
                if (store_go[i])
                begin
                    mem_res.val[i]  <= vk[i];
                    mem_res.addr[i] <= vj[i] + imm[i];
                end
                else
                begin
                    mem_res.val[i]  <= load_val;
                    mem_res.addr[i] <= mem_addr;
                end
            end
        end
    end

endmodule

// File: store_queue.sv
`timescale 1ns/1ps

module store_queue
    import lsq_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  mem_cdb_t mem_res,
    input  logic     new_store,
    input  tag_t     commit_tag,
    output mem_wr_t  mem_wr
);

    logic       slot_valid [ROB_DEPTH+1];
    xlen_word   slot_addr  [ROB_DEPTH+1];
    xlen_word   slot_data  [ROB_DEPTH+1];
    logic [2:0] slot_funct [ROB_DEPTH+1];

    xlen_word   c_addr;
    logic [1:0] c_off;
    logic [3:0] c_mask;
    xlen_word   c_data;

    // byte lanes for the store being committed.
    always_comb
    begin
        c_addr = slot_addr[commit_tag];
        c_off  = c_addr[1:0];
        case (slot_funct[commit_tag])
            sb:
            begin
                c_mask = 4'b0001 << c_off;
                c_data = slot_data[commit_tag] << {c_off, 3'b000};
            end
            sh:
            begin
                c_mask = 4'b0011 << {c_off[1], 1'b0};
                c_data = slot_data[commit_tag] << {c_off[1], 4'b0000};
            end
            default:
            begin
                c_mask = 4'b1111;
                c_data = slot_data[commit_tag];
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int t = 0; t <= ROB_DEPTH; t++)
            begin
                slot_valid[t] <= 1'b0;
            end
            mem_wr.valid <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < NUM_LDST_RS; i++)
            begin
                if (mem_res.valid[i] && mem_res.is_store[i])
                begin
                    slot_valid[mem_res.tag[i]] <= 1'b1;
                    slot_addr[mem_res.tag[i]]  <= mem_res.addr[i];
                    slot_data[mem_res.tag[i]]  <= mem_res.val[i];
                    slot_funct[mem_res.tag[i]] <= mem_res.funct[i];
                end
            end
            mem_wr.valid <= new_store && slot_valid[commit_tag];
            if (new_store)
            begin
                slot_valid[commit_tag] <= 1'b0;
                mem_wr.addr <= c_addr[MEM_ADDR_W+1:2];
                mem_wr.mask <= c_mask;
                mem_wr.data <= c_data;
            end
        end
    end

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem
    import lsq_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     mem_read,
    input  xlen_word mem_addr,
    output logic     mem_resp,
    output xlen_word mem_rdata,
    input  mem_wr_t  mem_wr
);

    xlen_word              mem [MEM_WORDS];
    logic                  read_prev;
    logic                  pending;
    logic [LAT_CNT_W-1:0]  lat_cnt;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic                  read_rise;

    assign read_rise = mem_read && !read_prev;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int w = 0; w < MEM_WORDS; w++)
            begin
                mem[w] <= '0;
            end
        end
        else if (mem_wr.valid)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (mem_wr.mask[b])
                begin
                    mem[mem_wr.addr][8*b +: 8] <= mem_wr.data[8*b +: 8];
                end
            end
        end
    end

    // the read is timed from the rising edge of mem_read.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            read_prev <= 1'b0;
            pending   <= 1'b0;
            lat_cnt   <= '0;
            mem_resp  <= 1'b0;
        end
        else
        begin
            read_prev <= mem_read;
            mem_resp  <= 1'b0;
            if (read_rise)
            begin
                pending <= 1'b1;
                lat_cnt <= LAT_CNT_W'(1);
                rd_addr <= mem_addr[MEM_ADDR_W+1:2];
            end
            else if (pending)
            begin
                if (lat_cnt == LAT_CNT_W'(MEM_READ_LATENCY - 1))
                begin
                    pending   <= 1'b0;
                    mem_resp  <= 1'b1;
                    mem_rdata <= mem[rd_addr];
                end
                else
                begin
                    lat_cnt <= lat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem
    import lsq_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          flush,
    input  logic          dispatch_valid,
    input  lsb_dispatch_t dispatch,
    output logic          lsb_ready,
    input  logic          new_store,
    input  tag_t          commit_tag,
    input  rob_bcast_t    rob_data,
    output mem_cdb_t      mem_res
);

    logic     mem_read;
    xlen_word mem_addr;
    logic     mem_resp;
    xlen_word mem_rdata;
    mem_wr_t  mem_wr;

    lsb_rs u_lsb_rs (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .lsb_ready      (lsb_ready),
        .new_store      (new_store),
        .rob_data       (rob_data),
        .mem_res        (mem_res),
        .mem_read       (mem_read),
        .mem_addr       (mem_addr),
        .mem_resp       (mem_resp),
        .mem_rdata      (mem_rdata)
    );

    // completed stores wait here until the ROB commits them.
    store_queue u_store_queue (
        .clk        (clk),
        .rst        (rst),
        .mem_res    (mem_res),
        .new_store  (new_store),
        .commit_tag (commit_tag),
        .mem_wr     (mem_wr)
    );

    data_mem u_data_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_read  (mem_read),
        .mem_addr  (mem_addr),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata),
        .mem_wr    (mem_wr)
    );

endmodule

// File: mem_subsystem_props.sv
`timescale 1ns/1ps

module mem_subsystem_props
    import lsq_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   flush,
    input logic                   dispatch_valid,
    input logic                   lsb_ready,
    input logic                   new_store,
    input logic                   mem_read,
    input logic                   mem_resp,
    input logic [NUM_LDST_RS-1:0] res_valid,
    input logic                   commit_filled
);

    // the bus is idle right after reset or flush.
    property p_idle_after_clear;
        @(posedge clk) (rst || flush) |=> (res_valid == '0);
    endproperty

    property p_no_dispatch_when_full;
        @(posedge clk) disable iff (rst) dispatch_valid |-> lsb_ready;
    endproperty

    // a read holds until memory answers.
    property p_read_held;
        @(posedge clk) disable iff (rst || flush) (mem_read && !mem_resp) |=> mem_read;
    endproperty

    property p_commit_filled;
        @(posedge clk) disable iff (rst) new_store |-> commit_filled;
    endproperty

    a_idle_after_clear: assert property (p_idle_after_clear)
        else $error("result bus active after reset or flush");
    a_no_dispatch_when_full: assert property (p_no_dispatch_when_full)
        else $error("dispatch while the buffer is full");
    a_read_held: assert property (p_read_held)
        else $error("mem_read dropped before mem_resp");
    a_commit_filled: assert property (p_commit_filled)
        else $error("commit names an empty store queue slot");

endmodule

bind mem_subsystem mem_subsystem_props u_props (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .lsb_ready      (lsb_ready),
    .new_store      (new_store),
    .mem_read       (mem_read),
    .mem_resp       (mem_resp),
    .res_valid      (mem_res.valid),
    .commit_filled  (u_store_queue.slot_valid[commit_tag])
);

// File: tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem
    import lsq_pkg::*;
();

    // the watchdog allows 50 times the summed rough test lengths in cycles.
    localparam int TEST_LEN_SUM   = 12 + 40 + 20 + 30 + 24;
    localparam int TIMEOUT_CYCLES = TEST_LEN_SUM * 50;

    logic          clk;
    logic          rst;
    logic          flush;
    logic          dispatch_valid;
    lsb_dispatch_t dispatch;
    logic          lsb_ready;
    logic          new_store;
    tag_t          commit_tag;
    rob_bcast_t    rob_data;
    mem_cdb_t      mem_res;

    integer   seed;
    int       err_cnt;
    int       check_cnt;
    int       test_ok;
    int       test_bad;
    int       neg_cnt;
    string    cur_test;
    xlen_word model_mem [MEM_WORDS];

    // expected result per reorder-buffer tag.
    logic       exp_pending [ROB_DEPTH+1];
    logic       exp_hold    [ROB_DEPTH+1];
    logic       exp_fast    [ROB_DEPTH+1];
    logic       exp_store   [ROB_DEPTH+1];
    logic [2:0] exp_funct   [ROB_DEPTH+1];
    xlen_word   exp_addr    [ROB_DEPTH+1];
    xlen_word   exp_val     [ROB_DEPTH+1];
    int         seen_at     [ROB_DEPTH+1];

    mem_subsystem u_dut (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .lsb_ready      (lsb_ready),
        .new_store      (new_store),
        .commit_tag     (commit_tag),
        .rob_data       (rob_data),
        .mem_res        (mem_res)
    );

    always #10 clk = ~clk;

    // ################################################
    // reference model
    // ################################################

    function automatic xlen_word load_value(input xlen_word w, input logic [2:0] f,
                                            input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * off));
        h = 16'(w >> (16 * off[1]));
        case (f)
            lb:      return {{24{b[7]}}, b};
            lbu:     return {24'h0, b};
            lh:      return {{16{h[15]}}, h};
            lhu:     return {16'h0, h};
            default: return w;
        endcase
    endfunction

    task automatic apply_store(input xlen_word a, input xlen_word d, input logic [2:0] f);
        int w;
        w = int'(a[MEM_ADDR_W+1:2]);
        case (f)
            sb:      model_mem[w][8*a[1:0] +: 8] = d[7:0];
            sh:      model_mem[w][16*a[1] +: 16] = d[15:0];
            default: model_mem[w] = d;
        endcase
    endtask

    // every bus result is compared with the model while the bus is stable.
    always @(negedge clk)
    begin
        tag_t     t;
        xlen_word want;
        neg_cnt++;
        if (!rst && dispatch_valid && lsb_ready)
        begin
            seen_at[dispatch.dest] = neg_cnt;
        end
        for (int i = 0; i < NUM_LDST_RS; i++)
        begin
            if (!rst && mem_res.valid[i])
            begin
                t = mem_res.tag[i];
                check_cnt++;
                assert (exp_pending[t] && !exp_hold[t])
                else
                begin
                    $display("result on tag %0d arrived while none was expected", t);
                    err_cnt++;
                end
                if (exp_pending[t])
                begin
                    if (exp_store[t])
                        want = exp_val[t];
                    else
                        want = load_value(model_mem[exp_addr[t][MEM_ADDR_W+1:2]],
                                          exp_funct[t], exp_addr[t][1:0]);
                    assert (mem_res.is_store[i] == exp_store[t])
                    else
                    begin
                        $display("Fail %s is_store tag %0d: expected %b actual %b",
                                 cur_test, t, exp_store[t], mem_res.is_store[i]);
                        err_cnt++;
                    end
                    assert (mem_res.funct[i] == exp_funct[t])
                    else
                    begin
                        $display("Fail %s funct tag %0d: expected %b actual %b",
                                 cur_test, t, exp_funct[t], mem_res.funct[i]);
                        err_cnt++;
                    end
                    assert (mem_res.addr[i] == exp_addr[t])
                    else
                    begin
                        $display("Fail %s addr tag %0d: expected %h actual %h",
                                 cur_test, t, exp_addr[t], mem_res.addr[i]);
                        err_cnt++;
                    end
                    assert (mem_res.val[i] == want)
                    else
                    begin
                        $display("Fail %s val tag %0d: expected %h actual %h",
                                 cur_test, t, want, mem_res.val[i]);
                        err_cnt++;
                    end
                    if (exp_fast[t])
                    begin
                        assert (neg_cnt == seen_at[t] + 2)
                        else
                        begin
                            $display("store on tag %0d reported at the wrong cycle", t);
                            err_cnt++;
                        end
                    end
                    exp_pending[t] = 1'b0;
                end
            end
        end
    end

    // ################################################
    // stimulus tasks
    // ################################################

    task automatic dispatch_op(input logic st, input logic [2:0] f, input xlen_word vj,
                               input xlen_word vk, input tag_t qj, input tag_t qk,
                               input xlen_word imm, input tag_t dest, input xlen_word a,
                               input xlen_word v, input logic hold);
        lsb_dispatch_t d;
        d.is_store       = st;
        d.funct          = f;
        d.vj             = vj;
        d.vk             = vk;
        d.qj             = qj;
        d.qk             = qk;
        d.imm            = imm;
        d.dest           = dest;
        exp_pending[dest] = 1'b1;
        exp_hold[dest]    = hold;
        exp_fast[dest]    = st && qj == '0 && qk == '0 && !hold;
        exp_store[dest]   = st;
        exp_funct[dest]   = f;
        exp_addr[dest]    = a;
        exp_val[dest]     = v;
        @(negedge clk);
        while (!lsb_ready)
            @(negedge clk);
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    task automatic wait_done(input tag_t t);
        while (exp_pending[t])
            @(posedge clk);
    endtask

    task automatic commit(input tag_t t);
        @(posedge clk);
        new_store  <= 1'b1;
        commit_tag <= t;
        apply_store(exp_addr[t], exp_val[t], exp_funct[t]);
        @(posedge clk);
        new_store <= 1'b0;
    endtask

    task automatic end_test(input int err_before);
        if (err_cnt == err_before)
            test_ok++;
        else
            test_bad++;
        $display("test %s done, %0d errors", cur_test, err_cnt - err_before);
    endtask

    // ################################################
    // tests
    // ################################################

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial
    begin
        xlen_word base;
        xlen_word data;
        xlen_word first_addr;
        logic [1:0] off;
        logic [1:0] hoff;
        int e0;
        seed = 32'h4639;
        clk = 1'b0;
        rst = 1'b1;
        flush = 1'b0;
        dispatch_valid = 1'b0;
        dispatch = '0;
        new_store = 1'b0;
        commit_tag = '0;
        rob_data = '0;
        err_cnt = 0;
        check_cnt = 0;
        test_ok = 0;
        test_bad = 0;
        neg_cnt = 0;
        cur_test = "reset";
        for (int w = 0; w < MEM_WORDS; w++)
            model_mem[w] = '0;
        for (int t = 0; t <= ROB_DEPTH; t++)
        begin
            exp_pending[t] = 1'b0;
            exp_hold[t] = 1'b0;
            seen_at[t] = 0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        e0 = err_cnt;
        cur_test = "word_round_trip";
        base = $random(seed) & 32'h3f0;
        data = $random(seed);
        first_addr = base + 4;
        dispatch_op(1'b1, sw, base, data, 0, 0, 4, 1, first_addr, data, 1'b0);
        wait_done(1);
        commit(1);
        dispatch_op(1'b0, lw, base, 0, 0, 0, 4, 2, first_addr, 0, 1'b0);
        wait_done(2);
        end_test(e0);

        e0 = err_cnt;
        cur_test = "sub_word_access";
        for (int k = 0; k < 2; k++)
        begin
            base = 32'h200 + ($random(seed) & 32'h0f0);
            off  = 2'($random(seed));
            hoff = {1'($random(seed)), 1'b0};
            data = $random(seed);
            dispatch_op(1'b1, sb, base, data, 0, 0, off, 1, base + off, data, 1'b0);
            wait_done(1);
            commit(1);
            data = $random(seed);
            dispatch_op(1'b1, sh, base, data, 0, 0, hoff, 2, base + hoff, data, 1'b0);
            wait_done(2);
            commit(2);
            dispatch_op(1'b0, lb, base, 0, 0, 0, off, 3, base + off, 0, 1'b0);
            dispatch_op(1'b0, lbu, base, 0, 0, 0, off, 4, base + off, 0, 1'b0);
            dispatch_op(1'b0, lh, base, 0, 0, 0, hoff, 5, base + hoff, 0, 1'b0);
            wait_done(3);
            dispatch_op(1'b0, lhu, base, 0, 0, 0, hoff, 6, base + hoff, 0, 1'b0);
            wait_done(4);
            wait_done(5);
            wait_done(6);
        end
        end_test(e0);

        e0 = err_cnt;
        cur_test = "store_ordering";
        base = 32'h300 + ($random(seed) & 32'h0fc);
        data = $random(seed);
        dispatch_op(1'b1, sw, base, data, 0, 0, 0, 1, base, data, 1'b0);
        dispatch_op(1'b0, lw, base, 0, 0, 0, 0, 2, base, 0, 1'b1);
        wait_done(1);
        repeat (6) @(posedge clk);
        commit(1);
        exp_hold[2] = 1'b0;
        wait_done(2);
        end_test(e0);

        e0 = err_cnt;
        cur_test = "operand_wakeup";
        base = 32'h100 + ($random(seed) & 32'h0fc);
        data = $random(seed);
        dispatch_op(1'b1, sw, 0, 0, 3, 4, 8, 1, base + 8, data, 1'b1);
        repeat (5) @(posedge clk);
        rob_data.vals[3] <= base;
        rob_data.vals[4] <= data;
        rob_data.ready[3] <= 1'b1;
        rob_data.ready[4] <= 1'b1;
        exp_hold[1] = 1'b0;
        wait_done(1);
        @(posedge clk);
        rob_data.ready <= '0;
        commit(1);
        dispatch_op(1'b0, lw, 0, 0, 5, 0, 8, 2, base + 8, 0, 1'b1);
        repeat (5) @(posedge clk);
        rob_data.vals[5] <= base;
        rob_data.ready[5] <= 1'b1;
        exp_hold[2] = 1'b0;
        wait_done(2);
        @(posedge clk);
        rob_data.ready <= '0;
        end_test(e0);

        e0 = err_cnt;
        cur_test = "full_buffer_flush";
        data = $random(seed);
        dispatch_op(1'b1, sw, 32'h80, data, 0, 0, 0, 1, 32'h80, data, 1'b0);
        wait_done(1);
        for (int t = 2; t <= 4; t++)
            dispatch_op(1'b0, lw, 32'h80, 0, 0, 0, 0, tag_t'(t), 32'h80, 0, 1'b1);
        repeat (5)
        begin
            @(negedge clk);
            assert (!lsb_ready)
            else
            begin
                $display("lsb_ready stayed high with every entry busy");
                err_cnt++;
            end
        end
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        assert (lsb_ready)
        else
        begin
            $display("lsb_ready did not return high after the flush");
            err_cnt++;
        end
        for (int t = 2; t <= 4; t++)
            exp_pending[t] = 1'b0;
        dispatch_op(1'b0, lw, first_addr, 0, 0, 0, 0, 5, first_addr, 0, 1'b0);
        wait_done(5);
        end_test(e0);

        $display("tests ok %0d, tests with errors %0d, results checked %0d, errors %0d",
                 test_ok, test_bad, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: mem_subsystem.f
lsq_pkg.sv
load_align.sv
lsb_rs.sv
store_queue.sv
data_mem.sv
mem_subsystem.sv
mem_subsystem_props.sv
tb_mem_subsystem.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mem_subsystem \
    -f mem_subsystem.f -o sim_mem_subsystem

./obj_dir/sim_mem_subsystem > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "run failed"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "run ended without a result"
    exit 1
fi
echo "run passed"
